//--- logic/aes_pkg.sv
////////////////////////////////////////////////////////////
// AES-128 shared definitions: widths, the two-view state
// word, the S-box lookup and GF(2^8) doubling.
////////////////////////////////////////////////////////////

package aes_pkg;

    localparam int block_width = 128;
    localparam int word_width  = 32;
    localparam int byte_width  = 8;
    localparam int round_width = 4;

    // Full rounds after the initial key addition.
    localparam logic [round_width-1:0] num_rounds = 4'd10;

    localparam logic [byte_width-1:0] rcon_init = 8'h01;

    // The AES state in FIPS column-major order.
    // bytes[0] and words[0] sit in the top bits.
    typedef union packed {
        logic [0:block_width/byte_width-1][byte_width-1:0] bytes;
        logic [0:block_width/word_width-1][word_width-1:0] words;
    } aes_state_t;

    // Substitution table, entry 0 in the top bits.
    localparam logic [0:255][byte_width-1:0] sbox_table = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [byte_width-1:0] sbox(input logic [byte_width-1:0] b);
        return sbox_table[b];
    endfunction

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1.
    function automatic logic [byte_width-1:0] xtime(input logic [byte_width-1:0] b);
        return {b[byte_width-2:0], 1'b0} ^ (8'h1b & {byte_width{b[byte_width-1]}});
    endfunction

endpackage

//--- logic/aes_ctrl.sv
////////////////////////////////////////////////////////////
// AES control: idle/run FSM that launches a block
// and pulses valid after the last round.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last_round,
    output logic load,
    output logic step,
    output logic valid
);

    // Low is idle, high is run.
    logic running;

    // Start only counts while idle.
    assign load = start && !running;
    assign step = running;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            valid   <= 1'b0;
        end else begin
            valid <= running && last_round;
            if (load) begin
                running <= 1'b1;
            end else if (running && last_round) begin
                running <= 1'b0;
            end
        end
    end

endmodule

//--- logic/aes_round_counter.sv
////////////////////////////////////////////////////////////
// Round counter: tracks rounds 1 to 10 and the Rcon byte.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_round_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           load,
    input  logic                           step,
    output logic                           last_round,
    output logic [aes_pkg::byte_width-1:0] rcon
);

    logic [aes_pkg::round_width-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            rcon  <= '0;
        end else if (load) begin
            count <= {{(aes_pkg::round_width-1){1'b0}}, 1'b1};
            rcon  <= aes_pkg::rcon_init;
        end else if (step) begin
            count <= count + 1'b1;
            // Next Rcon is the current one doubled in GF(2^8).
            rcon  <= aes_pkg::xtime(rcon);
        end
    end

    assign last_round = (count == aes_pkg::num_rounds);

endmodule

//--- logic/aes_key_schedule.sv
////////////////////////////////////////////////////////////
// AES-128 key schedule, one round key per step.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_key_schedule (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  logic                            step,
    input  logic [aes_pkg::block_width-1:0] key,
    input  logic [aes_pkg::byte_width-1:0]  rcon,
    output aes_pkg::aes_state_t             round_key
);

    localparam int word_bytes = aes_pkg::word_width / aes_pkg::byte_width;

    aes_pkg::aes_state_t prev_key;

    logic [aes_pkg::word_width-1:0] rot_word;
    logic [aes_pkg::word_width-1:0] sub_word;
    logic [aes_pkg::word_width-1:0] temp_word;

    // RotWord moves the top byte to the bottom.
    assign rot_word = {prev_key.words[3][aes_pkg::word_width-aes_pkg::byte_width-1:0],
                       prev_key.words[3][aes_pkg::word_width-1 -: aes_pkg::byte_width]};

    always_comb begin
        for (int i = 0; i < word_bytes; i++) begin
            sub_word[aes_pkg::byte_width*i +: aes_pkg::byte_width] =
                aes_pkg::sbox(rot_word[aes_pkg::byte_width*i +: aes_pkg::byte_width]);
        end
    end

    assign temp_word = sub_word ^ {rcon, {(aes_pkg::word_width-aes_pkg::byte_width){1'b0}}};

    // Each word chains on the one before it.
    always_comb begin
        round_key.words[0] = prev_key.words[0] ^ temp_word;
        round_key.words[1] = prev_key.words[1] ^ round_key.words[0];
        round_key.words[2] = prev_key.words[2] ^ round_key.words[1];
        round_key.words[3] = prev_key.words[3] ^ round_key.words[2];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_key <= '0;
        end else if (load) begin
            prev_key <= key;
        end else if (step) begin
            prev_key <= round_key;
        end
    end

endmodule

//--- logic/aes_round.sv
////////////////////////////////////////////////////////////
// AES round datapath: state register and one full round
// of SubBytes, ShiftRows, MixColumns and AddRoundKey.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_round (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  logic                            step,
    input  logic                            last_round,
    input  logic [aes_pkg::block_width-1:0] plaintext,
    input  logic [aes_pkg::block_width-1:0] key,
    input  aes_pkg::aes_state_t             round_key,
    output aes_pkg::aes_state_t             state
);

    localparam int num_bytes = aes_pkg::block_width / aes_pkg::byte_width;
    localparam int num_cols  = aes_pkg::block_width / aes_pkg::word_width;

    aes_pkg::aes_state_t cur_state;
    aes_pkg::aes_state_t sub_state;
    aes_pkg::aes_state_t shift_state;
    aes_pkg::aes_state_t mix_state;
    aes_pkg::aes_state_t round_out;

    // One column times the fixed MixColumns matrix.
    function automatic logic [aes_pkg::word_width-1:0] mix_column(
        input logic [aes_pkg::word_width-1:0] col
    );
        logic [aes_pkg::byte_width-1:0] a0, a1, a2, a3;
        logic [aes_pkg::byte_width-1:0] d0, d1, d2, d3;
        {a0, a1, a2, a3} = col;
        d0 = aes_pkg::xtime(a0);
        d1 = aes_pkg::xtime(a1);
        d2 = aes_pkg::xtime(a2);
        d3 = aes_pkg::xtime(a3);
        return {d0 ^ d1 ^ a1 ^ a2 ^ a3,
                a0 ^ d1 ^ d2 ^ a2 ^ a3,
                a0 ^ a1 ^ d2 ^ d3 ^ a3,
                d0 ^ a0 ^ a1 ^ a2 ^ d3};
    endfunction

    always_comb begin
        for (int i = 0; i < num_bytes; i++) begin
            sub_state.bytes[i] = aes_pkg::sbox(cur_state.bytes[i]);
        end
    end

    // Row r rotates left by r columns.
    always_comb begin
        for (int c = 0; c < num_cols; c++) begin
            for (int r = 0; r < num_cols; r++) begin
                shift_state.bytes[num_cols*c + r] =
                    sub_state.bytes[num_cols*((c + r) % num_cols) + r];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < num_cols; c++) begin
            mix_state.words[c] = mix_column(shift_state.words[c]);
        end
    end

    // Round 10 skips MixColumns.
    assign round_out = (last_round ? shift_state : mix_state) ^ round_key;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_state <= '0;
        end else if (load) begin
            cur_state <= plaintext ^ key;
        end else if (step) begin
            cur_state <= round_out;
        end
    end

    // Result holds until the next block finishes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= '0;
        end else if (step && last_round) begin
            state <= round_out;
        end
    end

endmodule

//--- logic/aes_core.sv
////////////////////////////////////////////////////////////
// AES-128 encryption core, one round per clock.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [aes_pkg::block_width-1:0] plaintext,
    input  logic [aes_pkg::block_width-1:0] key,
    output logic [aes_pkg::block_width-1:0] ciphertext,
    output logic                            valid
);

    logic                           load;
    logic                           step;
    logic                           last_round;
    logic [aes_pkg::byte_width-1:0] rcon;
    aes_pkg::aes_state_t            round_key;

    aes_ctrl i_aes_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .last_round (last_round),
        .load       (load),
        .step       (step),
        .valid      (valid)
    );

    aes_round_counter i_aes_round_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .last_round (last_round),
        .rcon       (rcon)
    );

    aes_key_schedule i_aes_key_schedule (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .key       (key),
        .rcon      (rcon),
        .round_key (round_key)
    );

    // The result register doubles as the ciphertext output.
    aes_round i_aes_round (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .last_round (last_round),
        .plaintext  (plaintext),
        .key        (key),
        .round_key  (round_key),
        .state      (ciphertext)
    );

endmodule

//--- test/aes_core_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the AES-128 core: file-driven vectors,
// latency, back-to-back blocks and ignored restarts.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_core_tb;

    localparam int    clk_period = 10;
    localparam int    seed       = 15863;
    localparam int    latency    = 10;
    localparam int    max_wait   = 20;
    localparam string stim_file  = "test/aes_core_stim.txt";

    logic         clk;
    logic         rst;
    logic         start;
    logic [127:0] plaintext;
    logic [127:0] key;
    logic [127:0] ciphertext;
    logic         valid;

    logic [127:0] keys[$];
    logic [127:0] plains[$];
    logic [127:0] expects[$];
    bit           disturbs[$];

    logic [127:0] prev_ct;
    int           errors;
    int           checks;
    bit           vectors_loaded;

    aes_core i_aes_core (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext),
        .valid      (valid)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_block(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_int(input string name, input int expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    function automatic logic [127:0] random_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Lines starting with # are comments.
    task automatic read_vectors();
        int           fd;
        int           fields;
        int           flag;
        string        line;
        logic [127:0] k;
        logic [127:0] p;
        logic [127:0] c;
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file %s.", stim_file);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h", flag, k, p, c);
                    if (fields == 4) begin
                        disturbs.push_back(flag != 0);
                        keys.push_back(k);
                        plains.push_back(p);
                        expects.push_back(c);
                    end else begin
                        errors++;
                        $display("A stimulus line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Called on a falling edge; returns on the falling edge where valid is high.
    task automatic run_vector(input int idx);
        string name;
        int    edges;
        bit    seen;
        name      = $sformatf("vector %0d", idx);
        start     = 1'b1;
        key       = keys[idx];
        plaintext = plains[idx];
        @(posedge clk);
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < max_wait) begin
            @(negedge clk);
            if (edges == 0) begin
                start = 1'b0;
            end
            // A second start in mid-run with junk data.
            if (disturbs[idx] && edges == 3) begin
                start     = 1'b1;
                key       = random_block();
                plaintext = random_block();
            end
            if (disturbs[idx] && edges == 5) begin
                start = 1'b0;
            end
            if (valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_block({name, " hold"}, prev_ct, ciphertext);
                @(posedge clk);
                edges++;
            end
        end
        if (!seen) begin
            errors++;
            $display("%s: valid never rose after start.", name);
            @(negedge clk);
        end else begin
            expect_int({name, " latency"}, latency, edges);
            check_block({name, " result"}, expects[idx], ciphertext);
        end
        prev_ct = ciphertext;
    endtask

    initial begin : watchdog
        wait (vectors_loaded);
        #((keys.size() * 12 + 10) * clk_period * 2);
        $display("Timeout: the run did not finish in the expected time.");
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        plaintext      = '0;
        key            = '0;
        prev_ct        = '0;
        errors         = 0;
        checks         = 0;
        vectors_loaded = 1'b0;
        void'($urandom(seed));
        read_vectors();
        if (keys.size() == 0) begin
            errors++;
            $display("No test vectors were read.");
        end
        vectors_loaded = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_block("reset ciphertext", '0, ciphertext);
            expect_int("reset valid", 0, valid);
        end
        rst = 1'b0;
        @(negedge clk);
        check_block("after reset ciphertext", '0, ciphertext);
        expect_int("after reset valid", 0, valid);
        // Each new start goes out in the cycle where valid is high.
        for (int i = 0; i < keys.size(); i++) begin
            run_vector(i);
        end
        @(negedge clk);
        expect_int("valid pulse width", 0, valid);
        repeat (3) @(negedge clk);
        check_block("final hold", prev_ct, ciphertext);
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- test/aes_core_stim.txt
# Columns: disturb flag, key, plaintext, expected ciphertext (hex).
# A disturb flag of 1 pulses start again with random data in mid-run.
0 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
1 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
0 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
0 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
1 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
0 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
0 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
1 00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
0 10a58869d74be5a374cf867cfb473859 00000000000000000000000000000000 6d251e6944b051e04eaa6fb4dbf78465

//--- filelist.f
logic/aes_pkg.sv
logic/aes_ctrl.sv
logic/aes_round_counter.sv
logic/aes_key_schedule.sv
logic/aes_round.sv
logic/aes_core.sv
test/aes_core_tb.sv

//--- Bender.yml
package:
  name: aes_core

sources:
  - logic/aes_pkg.sv
  - logic/aes_ctrl.sv
  - logic/aes_round_counter.sv
  - logic/aes_key_schedule.sv
  - logic/aes_round.sv
  - logic/aes_core.sv
  - target: test
    files:
      - test/aes_core_tb.sv
